//--- bench/l1_data_cache_testdata.txt
# op (0 load, 1 store), word address, store data, expected load data, expected hit
# every pass leaves each used line holding a tag other than its first access
# line 1, store miss, refill of stored words, store hits.
1 0484 11110000 00000000 0
1 0486 22220000 00000000 0
0 0484 00000000 11110000 0
0 0484 00000000 11110000 1
0 0486 00000000 22220000 1
1 0486 2222aaaa 00000000 1
0 0486 00000000 2222aaaa 1
1 0485 3333bbbb 00000000 1
0 0485 00000000 3333bbbb 1
# line 3, two tags that evict each other.
1 0cce 0b0b0b0b 00000000 0
0 0cce 00000000 0b0b0b0b 0
1 fc0d 0c0c0c0c 00000000 0
0 fc0d 00000000 0c0c0c0c 0
0 0cce 00000000 0b0b0b0b 0
0 fc0d 00000000 0c0c0c0c 0
0 0cce 00000000 0b0b0b0b 0
0 fc0d 00000000 0c0c0c0c 0
# line 1 again under a second tag, evicts the first one.
1 2944 44440000 00000000 0
0 2944 00000000 44440000 0
0 2944 00000000 44440000 1
1 2947 5555cccc 00000000 1
0 2947 00000000 5555cccc 1
0 2944 00000000 44440000 1
1 2946 6666dddd 00000000 1
0 2946 00000000 6666dddd 1

//--- bench/tb_l1_data_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module tb_l1_data_cache
	import l1_cache_ctrl_pkg::*;
	import l1_cache_bus_pkg::*;
;

	localparam string TESTDATA_FILE = "bench/l1_data_cache_testdata.txt";
	localparam int PASSES = 5;
	localparam int REQ_LIMIT = 40;
	localparam int IDLE_CYCLES = 6;

	logic iCLOCK;
	logic inRESET;
	logic iREQ_VALID;
	l1d_req_t iREQ;
	logic oBUSY;
	logic oRESP_VALID;
	l1d_resp_t oRESP;
	logic oMEM_REQ_VALID;
	l1d_mem_req_t oMEM_REQ;
	logic iMEM_VALID;
	logic [`L1D_DATA_W-1:0] iMEM_DATA;
	logic [`L1D_COUNT_W-1:0] oINFO_COUNT;

	logic [`L1D_DATA_W-1:0] mem_model [0:65535];
	logic [31:0] lcg_state;
	int mem_req_count = 0;
	l1d_mem_req_t last_mem_req;
	int error_count = 0;
	int check_count = 0;
	int watchdog_cycles = 0;

	// request list, one entry per data file row.
	logic req_store [$];
	logic [`L1D_ADDR_W-1:0] req_addr [$];
	logic [`L1D_DATA_W-1:0] req_wdata [$];
	logic [`L1D_DATA_W-1:0] req_rdata [$];
	logic req_hit [$];
	logic window [$];

	l1_data_cache l1_data_cache_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREQ_VALID(iREQ_VALID),
		.iREQ(iREQ),
		.oBUSY(oBUSY),
		.oRESP_VALID(oRESP_VALID),
		.oRESP(oRESP),
		.oMEM_REQ_VALID(oMEM_REQ_VALID),
		.oMEM_REQ(oMEM_REQ),
		.iMEM_VALID(iMEM_VALID),
		.iMEM_DATA(iMEM_DATA),
		.oINFO_COUNT(oINFO_COUNT)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			$display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	// ============================================================
	// memory model
	// ============================================================
	task automatic send_beat(input logic [`L1D_DATA_W-1:0] data);
		int gap;
		gap = int'(lcg_next() >> 30);
		repeat (gap) @(negedge iCLOCK);
		iMEM_VALID = 1'b1;
		iMEM_DATA = data;
		@(negedge iCLOCK);
		iMEM_VALID = 1'b0;
	endtask

	initial begin : memory_model
		l1d_mem_req_t mreq;
		iMEM_VALID = 1'b0;
		iMEM_DATA = '0;
		lcg_state = 32'd5;
		for (int a = 0; a < 65536; a++) begin
			mem_model[a] = lcg_next() ^ 32'(a);
		end
		forever begin
			@(negedge iCLOCK);
			if (oMEM_REQ_VALID) begin
				mreq = oMEM_REQ;
				mem_req_count++;
				last_mem_req = mreq;
				if (mreq.write) begin
					mem_model[mreq.addr] = mreq.wdata;
					// ack data is don't care.
					send_beat(lcg_next());
				end else begin
					for (int k = 0; k < 4; k++) begin
						send_beat(mem_model[{mreq.addr[`L1D_ADDR_W-1:`L1D_OFFSET_W], 2'(k)}]);
					end
				end
			end
		end
	end

	// ============================================================
	// stimulus and checks
	// ============================================================
	task automatic read_testdata();
		int fd;
		int fields;
		logic [8*128-1:0] text_line;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] hit;
		fd = $fopen(TESTDATA_FILE, "r");
		if (fd != 0) begin
			// comment lines fail the scan and are skipped.
			while ($fgets(text_line, fd) != 0) begin
				fields = $sscanf(text_line, "%h %h %h %h %h", op, addr, wdata, rdata, hit);
				if (fields == 5) begin
					req_store.push_back(op[0]);
					req_addr.push_back(addr[`L1D_ADDR_W-1:0]);
					req_wdata.push_back(wdata);
					req_rdata.push_back(rdata);
					req_hit.push_back(hit[0]);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_request(input int num, input logic is_store,
			input logic [`L1D_ADDR_W-1:0] addr, input logic [`L1D_DATA_W-1:0] wdata,
			input logic [`L1D_DATA_W-1:0] exp_data, input logic exp_hit);
		int cycles;
		int reqs_before;
		int resp_count;
		int resp_cycle;
		int hits;
		l1d_resp_t resp;
		l1d_req_t req;
		req.op = is_store ? OP_STORE : OP_LOAD;
		req.addr = addr;
		req.wdata = wdata;
		reqs_before = mem_req_count;
		resp_count = 0;
		resp_cycle = 0;
		resp = '0;
		iREQ = req;
		iREQ_VALID = 1'b1;
		@(negedge iCLOCK);
		iREQ_VALID = 1'b0;
		check_value("oBUSY", oBUSY, 1);
		cycles = 0;
		while (oBUSY && cycles < REQ_LIMIT) begin
			@(negedge iCLOCK);
			cycles++;
			if (oRESP_VALID) begin
				resp_count++;
				resp_cycle = cycles;
				resp = oRESP;
			end
		end
		if (oBUSY) begin
			$display("request %0d still busy after %0d cycles", num, REQ_LIMIT);
			error_count++;
		end
		if (is_store) begin
			check_value("oRESP_VALID pulses", resp_count, 0);
			check_value("memory requests", mem_req_count - reqs_before, 1);
			check_value("oMEM_REQ.write", last_mem_req.write, 1);
			check_value("oMEM_REQ.addr", last_mem_req.addr, addr);
			check_value("oMEM_REQ.wdata", last_mem_req.wdata, wdata);
		end else begin
			check_value("oRESP_VALID pulses", resp_count, 1);
			check_value("oRESP.rdata", resp.rdata, exp_data);
			check_value("oRESP.rdata vs memory model", resp.rdata, mem_model[addr]);
			check_value("oRESP.hit", resp.hit, exp_hit);
			if (exp_hit) begin
				check_value("hit latency", resp_cycle, 2);
				check_value("memory requests", mem_req_count - reqs_before, 0);
			end else begin
				check_value("memory requests", mem_req_count - reqs_before, 1);
				check_value("oMEM_REQ.write", last_mem_req.write, 0);
				check_value("oMEM_REQ.addr", last_mem_req.addr,
					{addr[`L1D_ADDR_W-1:`L1D_OFFSET_W], {`L1D_OFFSET_W{1'b0}}});
			end
		end
		window.push_back(exp_hit);
		if (window.size() > `L1D_WINDOW) begin
			window.delete(0);
		end
		// popcount pipeline needs 4 edges after the lookup.
		repeat (IDLE_CYCLES) @(negedge iCLOCK);
		hits = 0;
		foreach (window[k]) begin
			hits += window[k];
		end
		check_value("oINFO_COUNT", oINFO_COUNT, hits);
		$display("request %0d, %s at %h done, %0d errors so far", num,
			is_store ? "store" : "load", addr, error_count);
	endtask

	initial begin : main
		int num;
		inRESET = 1'b0;
		iREQ_VALID = 1'b0;
		iREQ = '0;
		num = 0;
		read_testdata();
		watchdog_cycles = req_store.size() * PASSES * 20 + 1000;
		repeat (16) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_value("oBUSY", oBUSY, 0);
		check_value("oRESP_VALID", oRESP_VALID, 0);
		check_value("oMEM_REQ_VALID", oMEM_REQ_VALID, 0);
		check_value("oINFO_COUNT", oINFO_COUNT, 0);
		$display("reset state done, %0d errors so far", error_count);
		if (req_store.size() == 0) begin
			$display("no requests could be read from %s", TESTDATA_FILE);
			error_count++;
		end else begin
			// the list is replayed so the hit window fills past 100 lookups.
			for (int p = 0; p < PASSES; p++) begin
				for (int i = 0; i < req_store.size(); i++) begin
					num++;
					run_request(num, req_store[i], req_addr[i], req_wdata[i],
						req_rdata[i], req_hit[i]);
				end
			end
		end
		$display("%0d requests, %0d checks, %0d errors", num, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge iCLOCK);
		$display("timeout, the run did not end within %0d clock cycles", watchdog_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- l1_data_cache.f
+incdir+verilog
verilog/l1_cache_ctrl_pkg.sv
verilog/l1_cache_bus_pkg.sv
verilog/l1_data_cache_ctrl.sv
verilog/l1_data_cache_refill_timer.sv
verilog/l1_data_cache_store.sv
verilog/l1_data_cache_counter.sv
verilog/l1_data_cache.sv
bench/tb_l1_data_cache.sv

//--- verilog/l1_cache_bus_pkg.sv
`default_nettype none

`include "l1_data_cache_defs.svh"

package l1_cache_bus_pkg;

	import l1_cache_ctrl_pkg::*;

	// processor request.
	typedef struct packed {
		l1d_op_t op;
		logic [`L1D_ADDR_W-1:0] addr;
		logic [`L1D_DATA_W-1:0] wdata;
	} l1d_req_t;

	// processor response, loads only.
	typedef struct packed {
		logic [`L1D_DATA_W-1:0] rdata;
		logic hit;
	} l1d_resp_t;

	// memory request, refills use a line-aligned address.
	typedef struct packed {
		logic write;
		logic [`L1D_ADDR_W-1:0] addr;
		logic [`L1D_DATA_W-1:0] wdata;
	} l1d_mem_req_t;

endpackage

`default_nettype wire

//--- verilog/l1_cache_ctrl_pkg.sv
`default_nettype none

package l1_cache_ctrl_pkg;

	// ============================================================
	// controller states
	// ============================================================
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL,
		WRITE_WAIT,
		RESPOND
	} l1d_state_t;

	// ============================================================
	// request opcodes
	// ============================================================
	typedef enum logic {
		OP_LOAD,
		OP_STORE
	} l1d_op_t;

endpackage

`default_nettype wire

//--- verilog/l1_data_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module l1_data_cache
	import l1_cache_bus_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire iREQ_VALID,
	input wire l1d_req_t iREQ,
	output logic oBUSY,
	output logic oRESP_VALID,
	output l1d_resp_t oRESP,
	output logic oMEM_REQ_VALID,
	output l1d_mem_req_t oMEM_REQ,
	input wire iMEM_VALID,
	input wire [`L1D_DATA_W-1:0] iMEM_DATA,
	output logic [`L1D_COUNT_W-1:0] oINFO_COUNT
);

	logic lookup;
	l1d_req_t lookup_req;
	logic lookup_hit;
	logic [`L1D_DATA_W-1:0] lookup_data;
	logic fill_valid;
	logic [`L1D_DATA_W-1:0] fill_data;
	logic store_write;
	logic timer_start;
	logic [`L1D_OFFSET_W-1:0] beat_offset;
	logic beat_last;
	logic cache_valid;
	logic cache_hit;

	l1_data_cache_ctrl ctrl_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iREQ_VALID(iREQ_VALID),
		.iREQ(iREQ),
		.iMEM_VALID(iMEM_VALID),
		.iMEM_DATA(iMEM_DATA),
		.iLOOKUP_HIT(lookup_hit),
		.iLOOKUP_DATA(lookup_data),
		.iBEAT_LAST(beat_last),
		.oBUSY(oBUSY),
		.oRESP_VALID(oRESP_VALID),
		.oRESP(oRESP),
		.oMEM_REQ_VALID(oMEM_REQ_VALID),
		.oMEM_REQ(oMEM_REQ),
		.oLOOKUP(lookup),
		.oLOOKUP_REQ(lookup_req),
		.oFILL_VALID(fill_valid),
		.oFILL_DATA(fill_data),
		.oSTORE_WRITE(store_write),
		.oTIMER_START(timer_start),
		.oCACHE_VALID(cache_valid),
		.oCACHE_HIT(cache_hit)
	);

	// beats are counted only while a refill is forwarded.
	l1_data_cache_refill_timer timer_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iSTART(timer_start),
		.iBEAT(fill_valid),
		.oOFFSET(beat_offset),
		.oLAST(beat_last)
	);

	l1_data_cache_store store_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iLOOKUP(lookup),
		.iREQ(lookup_req),
		.iFILL_VALID(fill_valid),
		.iFILL_DATA(fill_data),
		.iFILL_OFFSET(beat_offset),
		.iFILL_LAST(beat_last),
		.iSTORE_WRITE(store_write),
		.oHIT(lookup_hit),
		.oDATA(lookup_data)
	);

	l1_data_cache_counter counter_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.iCACHE_VALID(cache_valid),
		.iCACHE_HIT(cache_hit),
		.oINFO_COUNT(oINFO_COUNT)
	);

endmodule

`default_nettype wire

//--- verilog/l1_data_cache_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module l1_data_cache_counter (
	input wire iCLOCK,
	input wire inRESET,
	input wire iCACHE_VALID,
	input wire iCACHE_HIT,
	output logic [`L1D_COUNT_W-1:0] oINFO_COUNT
);

	localparam int GROUPS = `L1D_WINDOW / `L1D_GROUP;
	localparam int HALF = GROUPS / 2;

	logic [`L1D_WINDOW-1:0] history;
	logic [3:0] group_next [0:GROUPS-1];
	logic [3:0] group_q [0:GROUPS-1];
	logic [5:0] half_next [0:1];
	logic [5:0] half_q [0:1];
	logic [`L1D_COUNT_W-1:0] total_q;

	// ============================================================
	// hit history, newest flag in bit 0
	// ============================================================
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			history <= '0;
		end else if (iCACHE_VALID) begin
			history <= {history[`L1D_WINDOW-2:0], iCACHE_HIT};
		end
	end

	// ============================================================
	// population count
	// ============================================================
	always_comb begin
		for (int g = 0; g < GROUPS; g++) begin
			group_next[g] = 4'd0;
			for (int b = 0; b < `L1D_GROUP; b++) begin
				group_next[g] = group_next[g] + {3'd0, history[g*`L1D_GROUP + b]};
			end
		end
	end

	// five groups per half.
	always_comb begin
		for (int h = 0; h < 2; h++) begin
			half_next[h] = 6'd0;
			for (int k = 0; k < HALF; k++) begin
				half_next[h] = half_next[h] + {2'd0, group_q[h*HALF + k]};
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int g = 0; g < GROUPS; g++) begin
				group_q[g] <= 4'd0;
			end
			half_q[0] <= 6'd0;
			half_q[1] <= 6'd0;
			total_q <= '0;
		end else begin
			for (int g = 0; g < GROUPS; g++) begin
				group_q[g] <= group_next[g];
			end
			half_q[0] <= half_next[0];
			half_q[1] <= half_next[1];
			total_q <= {1'b0, half_q[0]} + {1'b0, half_q[1]};
		end
	end

	assign oINFO_COUNT = total_q;

endmodule

`default_nettype wire

//--- verilog/l1_data_cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module l1_data_cache_ctrl
	import l1_cache_ctrl_pkg::*;
	import l1_cache_bus_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire iREQ_VALID,
	input wire l1d_req_t iREQ,
	input wire iMEM_VALID,
	input wire [`L1D_DATA_W-1:0] iMEM_DATA,
	input wire iLOOKUP_HIT,
	input wire [`L1D_DATA_W-1:0] iLOOKUP_DATA,
	input wire iBEAT_LAST,
	output logic oBUSY,
	output logic oRESP_VALID,
	output l1d_resp_t oRESP,
	output logic oMEM_REQ_VALID,
	output l1d_mem_req_t oMEM_REQ,
	output logic oLOOKUP,
	output l1d_req_t oLOOKUP_REQ,
	output logic oFILL_VALID,
	output logic [`L1D_DATA_W-1:0] oFILL_DATA,
	output logic oSTORE_WRITE,
	output logic oTIMER_START,
	output logic oCACHE_VALID,
	output logic oCACHE_HIT
);

	l1d_state_t state;
	l1d_req_t req_q;
	logic lookup_done;
	logic resp_hit_q;
	logic mem_req_valid_q;
	l1d_mem_req_t mem_req_q;
	logic decide;

	// second lookup cycle, the registered hit flag is valid here.
	assign decide = (state == LOOKUP) && lookup_done;

	// ============================================================
	// sequencing
	// ============================================================
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			lookup_done <= 1'b0;
			resp_hit_q <= 1'b0;
			mem_req_valid_q <= 1'b0;
		end else begin
			mem_req_valid_q <= 1'b0;
			case (state)
				IDLE: begin
					if (iREQ_VALID) begin
						lookup_done <= 1'b0;
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (!lookup_done) begin
						lookup_done <= 1'b1;
					end else begin
						resp_hit_q <= iLOOKUP_HIT;
						if (req_q.op == OP_STORE) begin
							mem_req_valid_q <= 1'b1;
							state <= WRITE_WAIT;
						end else if (iLOOKUP_HIT) begin
							state <= RESPOND;
						end else begin
							mem_req_valid_q <= 1'b1;
							state <= REFILL;
						end
					end
				end
				REFILL: begin
					if (iMEM_VALID && iBEAT_LAST) begin
						state <= RESPOND;
					end
				end
				WRITE_WAIT: begin
					// write acknowledge ends the store.
					if (iMEM_VALID) begin
						state <= IDLE;
					end
				end
				RESPOND: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// request and memory request payload.
	always_ff @(posedge iCLOCK) begin
		if ((state == IDLE) && iREQ_VALID) begin
			req_q <= iREQ;
		end
		if (decide) begin
			if (req_q.op == OP_STORE) begin
				mem_req_q <= '{write: 1'b1, addr: req_q.addr, wdata: req_q.wdata};
			end else begin
				mem_req_q.write <= 1'b0;
				mem_req_q.addr <= {req_q.addr[`L1D_ADDR_W-1:`L1D_OFFSET_W],
					{`L1D_OFFSET_W{1'b0}}};
				mem_req_q.wdata <= '0;
			end
		end
	end

	// ============================================================
	// outputs
	// ============================================================
	assign oBUSY = (state != IDLE);
	assign oRESP_VALID = (state == RESPOND);
	assign oRESP = '{rdata: iLOOKUP_DATA, hit: resp_hit_q};
	assign oMEM_REQ_VALID = mem_req_valid_q;
	assign oMEM_REQ = mem_req_q;

	assign oLOOKUP = (state == LOOKUP) && !lookup_done;
	assign oLOOKUP_REQ = req_q;
	assign oFILL_VALID = (state == REFILL) && iMEM_VALID;
	assign oFILL_DATA = iMEM_DATA;
	assign oSTORE_WRITE = decide && (req_q.op == OP_STORE) && iLOOKUP_HIT;
	assign oTIMER_START = decide && (req_q.op == OP_LOAD) && !iLOOKUP_HIT;

	// one report per request.
	assign oCACHE_VALID = decide;
	assign oCACHE_HIT = iLOOKUP_HIT;

endmodule

`default_nettype wire

//--- verilog/l1_data_cache_defs.svh
`ifndef L1_DATA_CACHE_DEFS_SVH
`define L1_DATA_CACHE_DEFS_SVH

// ============================================================
// address and data widths
// ============================================================
`define L1D_ADDR_W 16
`define L1D_DATA_W 32

// line geometry, tag is what is left of the address.
`define L1D_INDEX_W 4
`define L1D_OFFSET_W 2
`define L1D_TAG_W 10

// ============================================================
// hit window
// ============================================================
`define L1D_WINDOW 100
`define L1D_GROUP 10
`define L1D_COUNT_W 7

`endif

//--- verilog/l1_data_cache_refill_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module l1_data_cache_refill_timer (
	input wire iCLOCK,
	input wire inRESET,
	input wire iSTART,
	input wire iBEAT,
	output logic [`L1D_OFFSET_W-1:0] oOFFSET,
	output logic oLAST
);

	logic [`L1D_OFFSET_W-1:0] offset;

	// offset of the next beat, wraps to zero after the last one.
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			offset <= '0;
		end else if (iSTART) begin
			offset <= '0;
		end else if (iBEAT) begin
			offset <= offset + 1'b1;
		end
	end

	assign oOFFSET = offset;

	// final word of the line.
	assign oLAST = &offset;

endmodule

`default_nettype wire

//--- verilog/l1_data_cache_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1_data_cache_defs.svh"

module l1_data_cache_store
	import l1_cache_bus_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire iLOOKUP,
	input wire l1d_req_t iREQ,
	input wire iFILL_VALID,
	input wire [`L1D_DATA_W-1:0] iFILL_DATA,
	input wire [`L1D_OFFSET_W-1:0] iFILL_OFFSET,
	input wire iFILL_LAST,
	input wire iSTORE_WRITE,
	output logic oHIT,
	output logic [`L1D_DATA_W-1:0] oDATA
);

	localparam int LINES = 1 << `L1D_INDEX_W;
	localparam int WORDS = 1 << (`L1D_INDEX_W + `L1D_OFFSET_W);

	logic [LINES-1:0] valid;
	logic [`L1D_TAG_W-1:0] tag_mem [0:LINES-1];
	logic [`L1D_DATA_W-1:0] data_mem [0:WORDS-1];
	logic hit_q;
	logic [`L1D_DATA_W-1:0] data_q;

	logic [`L1D_TAG_W-1:0] req_tag;
	logic [`L1D_INDEX_W-1:0] req_index;
	logic [`L1D_OFFSET_W-1:0] req_offset;

	assign req_tag = iREQ.addr[`L1D_ADDR_W-1 -: `L1D_TAG_W];
	assign req_index = iREQ.addr[`L1D_OFFSET_W +: `L1D_INDEX_W];
	assign req_offset = iREQ.addr[`L1D_OFFSET_W-1:0];

	// ============================================================
	// valid bits and hit flag
	// ============================================================
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid <= '0;
			hit_q <= 1'b0;
		end else begin
			if (iLOOKUP) begin
				hit_q <= valid[req_index] && (tag_mem[req_index] == req_tag);
			end
			// line becomes usable once the last word is in.
			if (iFILL_VALID && iFILL_LAST) begin
				valid[req_index] <= 1'b1;
			end
		end
	end

	// ============================================================
	// tag and data arrays
	// ============================================================
	always_ff @(posedge iCLOCK) begin
		if (iLOOKUP) begin
			data_q <= data_mem[{req_index, req_offset}];
		end
		if (iFILL_VALID) begin
			data_mem[{req_index, iFILL_OFFSET}] <= iFILL_DATA;
			// requested word goes straight to the read port.
			if (iFILL_OFFSET == req_offset) begin
				data_q <= iFILL_DATA;
			end
			if (iFILL_LAST) begin
				tag_mem[req_index] <= req_tag;
			end
		end
		if (iSTORE_WRITE) begin
			data_mem[{req_index, req_offset}] <= iREQ.wdata;
		end
	end

	assign oHIT = hit_q;
	assign oDATA = data_q;

endmodule

`default_nettype wire
